//--- src/lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// Data and address width of the LC-3b
`define LC3B_WORD_W 16

`define LC3B_RESET_PC 16'h0000

// A BR with no condition bits set never branches
`define LC3B_NOP 16'h0000

`endif

//--- src/lc3b_types_pkg.sv
`default_nettype none

`include "lc3b_defs.svh"

package lc3b_types_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100, // Also JSRR, told apart by bit 11
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100, // RET is JMP through R7
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic [2:0] gap;  // Mode bit and upper immediate bits
        lc3b_reg    src2;
    } lc3b_reg_fmt_t;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [3:0] unused;
        logic [7:0] trap_vect;
    } lc3b_trap_fmt_t;

    typedef union packed {
        lc3b_reg_fmt_t  reg_fmt;
        lc3b_trap_fmt_t trap_fmt;
    } lc3b_instr_u;

endpackage

`default_nettype wire

//--- src/if_stage_pkg.sv
`default_nettype none

package if_stage_pkg;

    import lc3b_types_pkg::*;

    // Source of the next PC value
    typedef enum logic [2:0] {
        pc_plus2     = 3'd0,
        pc_br_target = 3'd1,
        pc_sr1       = 3'd2,
        pc_trap_vec  = 3'd3,
        pc_held      = 3'd4
    } pc_sel_e;

    // Instruction memory request, driven by the fetch stage
    typedef struct packed {
        logic     read;
        lc3b_word address;
    } imem_req_t;

    // Instruction memory response, rdata valid while resp is high
    typedef struct packed {
        logic     resp;
        lc3b_word rdata;
    } imem_rsp_t;

    // Control transfer from the later stages
    typedef struct packed {
        logic     br_en;
        logic     jmp_jsr_en;
        logic     trap_en;
        logic     b11;       // JSR with PC offset when high
        lc3b_word pc_br;
        lc3b_word sr1_data;
        lc3b_word trap_mem;  // Service routine address read from the trap vector table
    } redirect_t;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word instruction;
        lc3b_reg  dest;
        lc3b_reg  src1;
        lc3b_reg  src2;
    } if_out_t;

endpackage

`default_nettype wire

//--- src/redirect_hold.sv
`default_nettype none

module redirect_hold
    import lc3b_types_pkg::*, if_stage_pkg::*;
(
    input  logic      clk,
    input  logic      if_stall_count_reset,
    input  redirect_t redirect,
    input  logic      resp,
    output lc3b_word  target,
    output logic      pending,
    output logic      now_valid,
    output lc3b_word  now_target
);

    assign now_valid = redirect.br_en | redirect.trap_en | redirect.jmp_jsr_en;

    always_comb begin
        if (redirect.br_en) begin
            now_target = redirect.pc_br;
        end else if (redirect.trap_en) begin
            now_target = redirect.trap_mem;
        end else if (redirect.b11) begin
            now_target = redirect.pc_br;     // JSR with an 11-bit offset
        end else begin
            now_target = redirect.sr1_data;  // JSRR, JMP and RET
        end
    end

    // A redirect that misses the response waits here for the next one
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            pending <= 1'b0;
        end else if (now_valid && !resp) begin
            pending <= 1'b1;
        end else if (resp) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (now_valid && !resp) begin
            target <= now_target;  // A newer redirect replaces an older one
        end
    end

endmodule

`default_nettype wire

//--- src/instr_reg.sv
`default_nettype none

`include "lc3b_defs.svh"

module instr_reg
    import lc3b_types_pkg::*;
(
    input  logic        clk,
    input  logic        if_stall_count_reset,
    input  logic        load,
    input  logic        flush,
    input  lc3b_word    rdata,
    output lc3b_instr_u instruction,
    output lc3b_reg     dest,
    output lc3b_reg     src1,
    output lc3b_reg     src2
);

    always_ff @(posedge clk) begin
        if (if_stall_count_reset || flush) begin
            instruction <= `LC3B_NOP;  // Flush beats a load in the same cycle
        end else if (load) begin
            instruction <= rdata;
        end
    end

    // Stores keep their data source in bits 11:9 as well
    assign dest = instruction.reg_fmt.dest;
    assign src1 = instruction.reg_fmt.src1;
    assign src2 = instruction.reg_fmt.src2;

endmodule

`default_nettype wire

//--- src/if_datapath.sv
`default_nettype none

`include "lc3b_defs.svh"

module if_datapath
    import lc3b_types_pkg::*, if_stage_pkg::*;
(
    input  logic      clk,
    input  logic      if_stall_count_reset,
    input  imem_rsp_t rsp,
    input  redirect_t redirect,
    input  logic      stall,
    output imem_req_t req,
    output lc3b_word  pc,
    output logic      ir_load,
    output lc3b_word  if_stall_count
);

    lc3b_word held_target;
    lc3b_word next_pc;
    logic     held_pending;
    logic     now_valid;
    logic     pc_load;
    logic     read_q;
    pc_sel_e  pc_sel;

    redirect_hold redirect_hold_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .redirect             (redirect),
        .resp                 (rsp.resp),
        .target               (held_target),
        .pending              (held_pending),
        .now_valid            (now_valid),
        .now_target           ()
    );

    // A redirect taken with the response goes through even under stall
    assign pc_load = rsp.resp & (now_valid | held_pending | ~stall);

    assign ir_load = rsp.resp & ~stall;

    always_comb begin
        if (now_valid && rsp.resp) begin
            if (redirect.br_en) begin
                pc_sel = pc_br_target;
            end else if (redirect.trap_en) begin
                pc_sel = pc_trap_vec;
            end else if (redirect.b11) begin
                pc_sel = pc_br_target;
            end else begin
                pc_sel = pc_sr1;
            end
        end else if (held_pending) begin
            pc_sel = pc_held;
        end else begin
            pc_sel = pc_plus2;
        end
    end

    always_comb begin
        case (pc_sel)
            pc_br_target: next_pc = redirect.pc_br;
            pc_sr1:       next_pc = redirect.sr1_data;
            pc_trap_vec:  next_pc = redirect.trap_mem;
            pc_held:      next_pc = held_target;
            default:      next_pc = pc + 16'd2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            pc <= `LC3B_RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // The fetch port asks for the current PC in every cycle once out of reset
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            read_q <= 1'b0;
        end else begin
            read_q <= 1'b1;
        end
    end

    assign req.read    = read_q;
    assign req.address = pc;

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            if_stall_count <= '0;
        end else if (req.read && !rsp.resp) begin
            if_stall_count <= if_stall_count + 16'd1;  // Wraps at the word width
        end
    end

endmodule

`default_nettype wire

//--- src/if_stage_top.sv
`default_nettype none

module if_stage_top
    import lc3b_types_pkg::*, if_stage_pkg::*;
(
    input  logic      clk,
    input  logic      if_stall_count_reset,
    input  imem_rsp_t imem_rsp,
    input  redirect_t redirect,
    input  logic      stall,
    input  logic      flush,
    output imem_req_t imem_req,
    output if_out_t   if_out,
    output lc3b_word  if_stall_count
);

    lc3b_word    pc;
    lc3b_instr_u instruction;
    lc3b_reg     dest;
    lc3b_reg     src1;
    lc3b_reg     src2;
    logic        ir_load;

    if_datapath if_datapath_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .rsp                  (imem_rsp),
        .redirect             (redirect),
        .stall                (stall),
        .req                  (imem_req),
        .pc                   (pc),
        .ir_load              (ir_load),
        .if_stall_count       (if_stall_count)
    );

    instr_reg instr_reg_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .load                 (ir_load),
        .flush                (flush),
        .rdata                (imem_rsp.rdata),
        .instruction          (instruction),
        .dest                 (dest),
        .src1                 (src1),
        .src2                 (src2)
    );

    assign if_out.pc          = pc;
    assign if_out.instruction = instruction;
    assign if_out.dest        = dest;
    assign if_out.src1        = src1;
    assign if_out.src2        = src2;

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // Released on a falling edge like the other inputs
    end

endmodule

`default_nettype wire

//--- dv/if_stage_tb.sv
`default_nettype none

`include "lc3b_defs.svh"

module if_stage_tb
    import lc3b_types_pkg::*, if_stage_pkg::*;
();

    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = 40 * NUM_TESTS + 100;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word count;
        lc3b_word held;
        logic     pending;
        logic     read;
    } model_t;

    logic        clk;
    logic        rst_init;
    logic        rst_test;
    logic        if_stall_count_reset;
    imem_rsp_t   imem_rsp = '0;
    imem_req_t   imem_req;
    redirect_t   redirect;
    logic        stall;
    logic        flush;
    if_out_t     if_out;
    lc3b_word    if_stall_count;

    model_t      ref_state = '0;
    logic        model_ok = 1'b0;
    logic [2:0]  mem_mode;          // 0 to 3 is a fixed wait, 4 draws the wait from the LFSR
    logic [1:0]  wait_left = '0;
    logic        mem_busy = 1'b0;
    logic [15:0] lfsr = 16'd68;
    int          checks = 0;
    int          mismatches = 0;
    int          cycles = 0;
    int          test_num = 0;
    int          errs_before = 0;

    assign if_stall_count_reset = rst_init | rst_test;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst_init)
    );

    if_stage_top dut_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .imem_rsp             (imem_rsp),
        .redirect             (redirect),
        .stall                (stall),
        .flush                (flush),
        .imem_req             (imem_req),
        .if_out               (if_out),
        .if_stall_count       (if_stall_count)
    );

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic redirect_t redirect_of(input logic br, input logic jmp,
                                              input logic trap, input logic b11);
        redirect_t r;
        r.br_en      = br;
        r.jmp_jsr_en = jmp;
        r.trap_en    = trap;
        r.b11        = b11;
        r.pc_br      = 16'h3000;
        r.sr1_data   = 16'h2468;
        r.trap_mem   = 16'h0400;
        return r;
    endfunction

    // Expected state after one rising edge
    function automatic model_t predict_next(input model_t s, input logic rst,
                                            input imem_rsp_t rsp, input redirect_t rd,
                                            input logic stl, input logic fl);
        model_t   n;
        logic     rd_now;
        lc3b_word tgt;
        n      = s;
        rd_now = rd.br_en | rd.trap_en | rd.jmp_jsr_en;
        if (rd.br_en)
            tgt = rd.pc_br;
        else if (rd.trap_en)
            tgt = rd.trap_mem;
        else
            tgt = rd.b11 ? rd.pc_br : rd.sr1_data;
        if (rst) begin
            n.pc      = `LC3B_RESET_PC;
            n.ir      = `LC3B_NOP;
            n.count   = 16'd0;
            n.pending = 1'b0;
            n.read    = 1'b0;
        end else begin
            n.read = 1'b1;
            if (s.read && !rsp.resp)
                n.count = s.count + 16'd1;
            if (rsp.resp && rd_now)
                n.pc = tgt;
            else if (rsp.resp && s.pending)
                n.pc = s.held;
            else if (rsp.resp && !stl)
                n.pc = s.pc + 16'd2;
            if (fl)
                n.ir = `LC3B_NOP;
            else if (rsp.resp && !stl)
                n.ir = rsp.rdata;
            if (rd_now && !rsp.resp) begin
                n.pending = 1'b1;
                n.held    = tgt;
            end else if (rsp.resp) begin
                n.pending = 1'b0;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input lc3b_word expected,
                               input lc3b_word actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_resp();
        do begin
            @(posedge clk);
        end while (!imem_rsp.resp);
    endtask

    task automatic set_mem_wait(input logic [2:0] mode);
        @(posedge clk);
        mem_mode = mode;
        wait_resp();  // Lets the request already in flight finish
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (mismatches == errs_before)
            $display("Test %0d (%s): ok", test_num, name);
        else
            $display("Test %0d (%s): %0d mismatches", test_num, name, mismatches - errs_before);
        errs_before = mismatches;
    endtask

    always @(negedge clk) begin
        if (!imem_req.read) begin
            mem_busy = 1'b0;
            imem_rsp = '0;
        end else begin
            if (!mem_busy) begin
                if (mem_mode[2]) begin
                    for (int i = 0; i < 2; i++) begin
                        lfsr      = lfsr_next(lfsr);
                        wait_left = {wait_left[0], lfsr[0]};
                    end
                end else begin
                    wait_left = mem_mode[1:0];
                end
                mem_busy = 1'b1;
            end
            if (wait_left == 2'd0) begin
                imem_rsp.resp  = 1'b1;
                imem_rsp.rdata = imem_req.address ^ 16'hA5A5;
                mem_busy       = 1'b0;
            end else begin
                imem_rsp  = '0;
                wait_left = wait_left - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (model_ok) begin
            check_value("pc", ref_state.pc, if_out.pc);
            check_value("instruction", ref_state.ir, if_out.instruction);
            check_value("dest", {13'd0, ref_state.ir[11:9]}, {13'd0, if_out.dest});
            check_value("src1", {13'd0, ref_state.ir[8:6]}, {13'd0, if_out.src1});
            check_value("src2", {13'd0, ref_state.ir[2:0]}, {13'd0, if_out.src2});
            check_value("if_stall_count", ref_state.count, if_stall_count);
            check_value("imem_req.read", {15'd0, ref_state.read}, {15'd0, imem_req.read});
            check_value("imem_req.address", ref_state.pc, imem_req.address);
        end
        if (if_stall_count_reset)
            model_ok = 1'b1;  // State is known from the first reset edge on
        ref_state = predict_next(ref_state, if_stall_count_reset, imem_rsp, redirect,
                                 stall, flush);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        redirect = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        rst_test = 1'b0;
        mem_mode = 3'd4;

        do begin
            @(posedge clk);
        end while (rst_init);
        repeat (6) @(negedge clk);
        report_test("reset and first fetch");

        repeat (10) wait_resp();
        @(negedge clk);
        report_test("sequential fetch with random waits");

        set_mem_wait(3'd0);  // A response in every cycle from here on
        @(negedge clk);
        redirect = redirect_of(1'b1, 1'b1, 1'b1, 1'b0);  // Branch beats trap and jump
        @(negedge clk);
        redirect = redirect_of(1'b0, 1'b1, 1'b1, 1'b1);
        @(negedge clk);
        redirect = redirect_of(1'b0, 1'b1, 1'b0, 1'b1);
        @(negedge clk);
        redirect = redirect_of(1'b0, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        redirect = '0;
        repeat (3) @(negedge clk);
        report_test("redirect with response");

        set_mem_wait(3'd3);
        @(negedge clk);
        redirect = redirect_of(1'b0, 1'b1, 1'b0, 1'b0);  // First of three wait cycles
        @(negedge clk);
        redirect = '0;
        wait_resp();
        @(negedge clk);
        redirect = redirect_of(1'b1, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        redirect = '0;
        stall    = 1'b1;  // The held target must load even while stalled
        wait_resp();
        @(negedge clk);
        stall = 1'b0;
        report_test("redirect during a wait");

        set_mem_wait(3'd0);
        @(negedge clk);
        stall = 1'b1;
        repeat (4) @(negedge clk);
        redirect = redirect_of(1'b1, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        redirect = '0;
        repeat (2) @(negedge clk);
        stall = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (2) @(negedge clk);
        report_test("stall and flush");

        set_mem_wait(3'd3);
        @(negedge clk);
        redirect = redirect_of(1'b0, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        redirect = '0;
        rst_test = 1'b1;  // Lands while the redirect is still pending
        @(negedge clk);
        rst_test = 1'b0;
        repeat (2) wait_resp();
        @(negedge clk);
        report_test("reset mid-run");

        $display("%0d tests, %0d checks, %0d mismatches", test_num, checks, mismatches);
        if (mismatches == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/lc3b_types_pkg.sv
src/if_stage_pkg.sv
src/redirect_hold.sv
src/instr_reg.sv
src/if_datapath.sv
src/if_stage_top.sv
dv/clk_gen.sv
dv/if_stage_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module if_stage_tb -f sources.f -o if_stage_sim

output=$(./obj_dir/if_stage_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
